//--- rtl/cu_pkg.sv
package cu_pkg;

    // ----------------------------------------
    // Merge operation, value 3 falls back to add
    // ----------------------------------------
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_MIN = 2'd1,
        OP_MAX = 2'd2
    } cu_op_e;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    // CTRL: [0] enable, [2:1] op, [3] flush (write one)
    // STATUS: [0] flush busy, upper bits occupied count
    // MERGED: 16-bit wrapping merge counter
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_STATUS = 2'd1,
        REG_MERGED = 2'd2
    } cu_reg_e;

    // ----------------------------------------
    // Coalescer FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WAIT  = 2'd1,
        ST_FLUSH = 2'd2
    } cu_state_e;

endpackage

//--- rtl/cu_fifo.sv
`timescale 1ns/10ps

module cu_fifo #(
    parameter int C_WIDTH = 32,
    parameter int C_DEPTH = 4
) (
    input  logic               clk_i,
    input  logic               rst_i,

    // Push side
    input  logic               wr_en_i,
    input  logic [C_WIDTH-1:0] wdata_i,
    // High while not full
    output logic               ready_o,

    // Pop side
    input  logic               rd_en_i,
    output logic [C_WIDTH-1:0] rdata_o,
    output logic               rdata_valid_o,
    output logic               empty_o
);

    // Pointer and count widths
    localparam int PTR_W = (C_DEPTH > 1) ? $clog2(C_DEPTH) : 1;
    localparam int CNT_W = $clog2(C_DEPTH + 1);

    logic [CNT_W-1:0]   data_count;
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [PTR_W-1:0]   next_head;
    logic [PTR_W-1:0]   next_tail;
    logic               push_en;
    logic               pop_en;

    // Storage, no reset needed
    logic [C_WIDTH-1:0] mem [C_DEPTH];

    // ----------------------------------------
    // Accepted strobes
    // ----------------------------------------
    assign push_en = wr_en_i && ready_o;
    assign pop_en  = rd_en_i && !empty_o;

    // Flags straight from the count
    assign ready_o = (data_count != CNT_W'(C_DEPTH));
    assign empty_o = (data_count == '0);

    // ----------------------------------------
    // Occupancy count
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_count <= '0;
        end else begin
            case ({push_en, pop_en})
                2'b10:   data_count <= data_count + 1'b1;
                2'b01:   data_count <= data_count - 1'b1;
                // Both or neither leave count unchanged
                default: data_count <= data_count;
            endcase
        end
    end

    // ----------------------------------------
    // Pointers, wrap at depth
    // ----------------------------------------
    always_comb begin
        next_head = head;
        next_tail = tail;
        if (pop_en) begin
            next_head = (head == PTR_W'(C_DEPTH - 1)) ? '0 : head + 1'b1;
        end
        if (push_en) begin
            next_tail = (tail == PTR_W'(C_DEPTH - 1)) ? '0 : tail + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= next_head;
            tail <= next_tail;
        end
    end

    // Write into tail slot
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem[tail] <= wdata_i;
        end
    end

    // ----------------------------------------
    // Registered pop, zero when idle
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o       <= '0;
            rdata_valid_o <= 1'b0;
        end else if (pop_en) begin
            rdata_o       <= mem[head];
            rdata_valid_o <= 1'b1;
        end else begin
            rdata_o       <= '0;
            rdata_valid_o <= 1'b0;
        end
    end

    // Count bounded by depth across all push/pop mixes
    a_count_bound : assert property (
        @(posedge clk_i) disable iff (rst_i)
        data_count <= CNT_W'(C_DEPTH)
    );

endmodule

//--- rtl/cu_regs.sv
`timescale 1ns/10ps

module cu_regs #(
    parameter int TABLE_DEPTH = 8
) (
    input  logic                              clk_i,
    input  logic                              rst_i,

    // Config port
    input  logic                              cfg_we_i,
    input  cu_pkg::cu_reg_e                   cfg_addr_i,
    input  logic [15:0]                       cfg_wdata_i,
    output logic [15:0]                       cfg_rdata_o,

    // Status from coalescer
    input  logic                              flush_busy_i,
    input  logic [$clog2(TABLE_DEPTH):0]      occupied_i,
    input  logic                              merge_i,

    // Control to coalescer
    output logic                              enable_o,
    output cu_pkg::cu_op_e                    op_o,
    output logic                              flush_o
);

    import cu_pkg::*;

    localparam int OCC_W = $clog2(TABLE_DEPTH) + 1;

    logic        ctrl_wr;
    logic        flush_req;
    logic [15:0] merged_q;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    assign ctrl_wr   = cfg_we_i && (cfg_addr_i == REG_CTRL);
    // Flush bit only counts when idle
    assign flush_req = ctrl_wr && cfg_wdata_i[3] && !flush_busy_i;

    // Enable and op fields
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_o <= 1'b1;
            op_o     <= OP_ADD;
        end else if (ctrl_wr) begin
            enable_o <= cfg_wdata_i[0];
            op_o     <= cu_op_e'(cfg_wdata_i[2:1]);
        end
    end

    // Self-clearing flush pulse
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            flush_o <= 1'b0;
        end else begin
            // Pulse cycle already reads as busy so a repeat write is dropped
            flush_o <= flush_req;
        end
    end

    // ----------------------------------------
    // Wrapping merged-event counter
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            merged_q <= '0;
        end else if (merge_i) begin
            merged_q <= merged_q + 16'd1;
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            REG_CTRL: begin
                // Flush bit reads back as zero
                cfg_rdata_o[0]   = enable_o;
                cfg_rdata_o[2:1] = op_o;
            end
            REG_STATUS: begin
                cfg_rdata_o[0]       = flush_busy_i;
                cfg_rdata_o[OCC_W:1] = occupied_i;
            end
            REG_MERGED: cfg_rdata_o = merged_q;
            default:    cfg_rdata_o = '0;
        endcase
    end

    // Busy feedback from the coalescer blocks a back-to-back pulse
    a_flush_single : assert property (
        @(posedge clk_i) disable iff (rst_i)
        flush_o |=> !flush_o
    );

endmodule

//--- rtl/cu_coalescer.sv
`timescale 1ns/10ps

module cu_coalescer #(
    parameter int IDX_W       = 16,
    parameter int VAL_W       = 16,
    parameter int TABLE_DEPTH = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_i,

    // Input FIFO side
    input  logic                          in_empty_i,
    input  logic [IDX_W+VAL_W-1:0]        in_data_i,
    input  logic                          in_valid_i,
    output logic                          in_rd_en_o,

    // Output FIFO side
    input  logic                          out_ready_i,
    output logic                          out_wr_en_o,
    output logic [IDX_W+VAL_W-1:0]        out_data_o,

    // Register block side
    input  logic                          enable_i,
    input  cu_pkg::cu_op_e                op_i,
    input  logic                          flush_i,
    output logic                          flush_busy_o,
    output logic [$clog2(TABLE_DEPTH):0]  occupied_o,
    output logic                          merge_o
);

    import cu_pkg::*;

    localparam int SLOT_W = $clog2(TABLE_DEPTH);
    localparam int OCC_W  = SLOT_W + 1;

    // FSM
    cu_state_e          state_q;
    cu_state_e          state_d;
    logic               pend_q;
    logic               pend_d;
    logic [SLOT_W-1:0]  scan_q;
    logic [SLOT_W-1:0]  scan_d;
    logic [OCC_W-1:0]   occ_q;

    // Table: valid, full index, accumulated value
    logic [TABLE_DEPTH-1:0] valid_q;
    logic [IDX_W-1:0]       idx_q [TABLE_DEPTH];
    logic [VAL_W-1:0]       val_q [TABLE_DEPTH];

    // Incoming event fields
    logic [IDX_W-1:0]   ev_idx;
    logic [VAL_W-1:0]   ev_val;
    logic [SLOT_W-1:0]  ev_slot;
    logic [VAL_W-1:0]   cur_val;
    logic               hit;
    logic [VAL_W-1:0]   merged_val;
    logic [VAL_W-1:0]   wr_val;

    // Table update strobes
    logic               tbl_wr;
    logic               tbl_clr;
    logic               occ_inc;
    logic               occ_dec;

    // ----------------------------------------
    // Event decode and lookup
    // ----------------------------------------
    assign ev_idx  = in_data_i[IDX_W+VAL_W-1:VAL_W];
    assign ev_val  = in_data_i[VAL_W-1:0];
    // Direct mapped on low index bits
    assign ev_slot = ev_idx[SLOT_W-1:0];
    assign cur_val = val_q[ev_slot];
    assign hit     = valid_q[ev_slot] && (idx_q[ev_slot] == ev_idx);

    // Merge op, unsigned; op 3 behaves as add
    always_comb begin
        case (op_i)
            OP_MIN:  merged_val = (ev_val < cur_val) ? ev_val : cur_val;
            OP_MAX:  merged_val = (ev_val > cur_val) ? ev_val : cur_val;
            default: merged_val = cur_val + ev_val;
        endcase
    end

    // Merge on hit, fresh value on install
    assign wr_val = hit ? merged_val : ev_val;

    assign occupied_o   = occ_q;
    // Busy from flush pulse until scan ends
    assign flush_busy_o = flush_i || pend_q || (state_q == ST_FLUSH);

    // ----------------------------------------
    // Next state and datapath control
    // ----------------------------------------
    always_comb begin
        state_d     = state_q;
        pend_d      = pend_q;
        scan_d      = scan_q;
        in_rd_en_o  = 1'b0;
        out_wr_en_o = 1'b0;
        out_data_o  = '0;
        merge_o     = 1'b0;
        tbl_wr      = 1'b0;
        tbl_clr     = 1'b0;
        occ_inc     = 1'b0;
        occ_dec     = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (flush_i || pend_q) begin
                    // Start scan at slot 0
                    state_d = ST_FLUSH;
                    scan_d  = '0;
                    pend_d  = 1'b0;
                end else if (!in_empty_i && out_ready_i) begin
                    // Room reserved in output FIFO for one push
                    in_rd_en_o = 1'b1;
                    state_d    = ST_WAIT;
                end
            end
            ST_WAIT: begin
                // Flush during event handling waits its turn
                if (flush_i) begin
                    pend_d = 1'b1;
                end
                state_d = ST_IDLE;
                if (in_valid_i) begin
                    if (!enable_i) begin
                        // Bypass, table untouched
                        out_wr_en_o = 1'b1;
                        out_data_o  = in_data_i;
                    end else if (hit) begin
                        tbl_wr  = 1'b1;
                        merge_o = 1'b1;
                    end else begin
                        tbl_wr = 1'b1;
                        if (valid_q[ev_slot]) begin
                            // Conflict, old entry leaves
                            out_wr_en_o = 1'b1;
                            out_data_o  = {idx_q[ev_slot], val_q[ev_slot]};
                        end else begin
                            occ_inc = 1'b1;
                        end
                    end
                end
            end
            ST_FLUSH: begin
                // Stall only on a valid slot with a full output
                if (!valid_q[scan_q] || out_ready_i) begin
                    if (valid_q[scan_q]) begin
                        out_wr_en_o = 1'b1;
                        out_data_o  = {idx_q[scan_q], val_q[scan_q]};
                        tbl_clr     = 1'b1;
                        occ_dec     = 1'b1;
                    end
                    scan_d = scan_q + 1'b1;
                    if (scan_q == SLOT_W'(TABLE_DEPTH - 1)) begin
                        state_d = ST_IDLE;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            pend_q  <= 1'b0;
            scan_q  <= '0;
            occ_q   <= '0;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
            scan_q  <= scan_d;
            if (occ_inc) begin
                occ_q <= occ_q + 1'b1;
            end else if (occ_dec) begin
                occ_q <= occ_q - 1'b1;
            end
            if (tbl_wr) begin
                valid_q[ev_slot] <= 1'b1;
            end
            if (tbl_clr) begin
                valid_q[scan_q] <= 1'b0;
            end
        end
    end

    // Table payload
    always_ff @(posedge clk_i) begin
        if (tbl_wr) begin
            idx_q[ev_slot] <= ev_idx;
            val_q[ev_slot] <= wr_val;
        end
    end

    // Output FIFO never refuses a push
    a_push_room : assert property (
        @(posedge clk_i) disable iff (rst_i)
        out_wr_en_o |-> out_ready_i
    );

    // Pop data lands exactly one cycle after the pop
    a_valid_in_wait : assert property (
        @(posedge clk_i) disable iff (rst_i)
        in_valid_i |-> (state_q == ST_WAIT)
    );

endmodule

//--- rtl/cu_top.sv
`timescale 1ns/10ps

module cu_top #(
    parameter int IDX_W       = 16,
    parameter int VAL_W       = 16,
    parameter int TABLE_DEPTH = 8,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic              clk_i,
    input  logic              rst_i,

    // Event input
    input  logic              ev_wr_en_i,
    input  logic [IDX_W-1:0]  ev_idx_i,
    input  logic [VAL_W-1:0]  ev_val_i,
    output logic              ev_ready_o,

    // Merged event output
    input  logic              out_rd_en_i,
    output logic              out_valid_o,
    output logic [IDX_W-1:0]  out_idx_o,
    output logic [VAL_W-1:0]  out_val_o,
    output logic              out_empty_o,

    // Config port
    input  logic              cfg_we_i,
    input  cu_pkg::cu_reg_e   cfg_addr_i,
    input  logic [15:0]       cfg_wdata_i,
    output logic [15:0]       cfg_rdata_o
);

    import cu_pkg::*;

    localparam int DATA_W = IDX_W + VAL_W;
    localparam int OCC_W  = $clog2(TABLE_DEPTH) + 1;

    // Input FIFO to coalescer
    logic              in_rd_en;
    logic [DATA_W-1:0] in_rdata;
    logic              in_rdata_valid;
    logic              in_empty;

    // Coalescer to output FIFO
    logic              out_wr_en;
    logic [DATA_W-1:0] out_wdata;
    logic              out_ready;
    logic [DATA_W-1:0] out_rdata;

    // Register block links
    logic              enable;
    cu_op_e            op;
    logic              flush;
    logic              flush_busy;
    logic [OCC_W-1:0]  occupied;
    logic              merge;

    // ----------------------------------------
    // Input FIFO, index in upper bits
    // ----------------------------------------
    cu_fifo #(
        .C_WIDTH (DATA_W),
        .C_DEPTH (FIFO_DEPTH)
    ) u_in_fifo (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wr_en_i       (ev_wr_en_i),
        .wdata_i       ({ev_idx_i, ev_val_i}),
        .ready_o       (ev_ready_o),
        .rd_en_i       (in_rd_en),
        .rdata_o       (in_rdata),
        .rdata_valid_o (in_rdata_valid),
        .empty_o       (in_empty)
    );

    cu_coalescer #(
        .IDX_W       (IDX_W),
        .VAL_W       (VAL_W),
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_coalescer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in_empty_i   (in_empty),
        .in_data_i    (in_rdata),
        .in_valid_i   (in_rdata_valid),
        .in_rd_en_o   (in_rd_en),
        .out_ready_i  (out_ready),
        .out_wr_en_o  (out_wr_en),
        .out_data_o   (out_wdata),
        .enable_i     (enable),
        .op_i         (op),
        .flush_i      (flush),
        .flush_busy_o (flush_busy),
        .occupied_o   (occupied),
        .merge_o      (merge)
    );

    // ----------------------------------------
    // Output FIFO, zero word when not valid
    // ----------------------------------------
    cu_fifo #(
        .C_WIDTH (DATA_W),
        .C_DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wr_en_i       (out_wr_en),
        .wdata_i       (out_wdata),
        .ready_o       (out_ready),
        .rd_en_i       (out_rd_en_i),
        .rdata_o       (out_rdata),
        .rdata_valid_o (out_valid_o),
        .empty_o       (out_empty_o)
    );

    // Split output word
    assign out_idx_o = out_rdata[DATA_W-1:VAL_W];
    assign out_val_o = out_rdata[VAL_W-1:0];

    cu_regs #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .flush_busy_i (flush_busy),
        .occupied_i   (occupied),
        .merge_i      (merge),
        .enable_o     (enable),
        .op_o         (op),
        .flush_o      (flush)
    );

endmodule

//--- tests/cu_tb_model.svh
`ifndef CU_TB_MODEL_SVH
`define CU_TB_MODEL_SVH

// ----------------------------------------
// Reference table and expected output
// ----------------------------------------
localparam int M_DEPTH  = 8;
localparam int M_SLOT_W = 3;

logic        m_valid [M_DEPTH];
logic [15:0] m_idx   [M_DEPTH];
logic [15:0] m_val   [M_DEPTH];
logic        m_enable;
logic [1:0]  m_op;
int          m_occ;
logic [15:0] m_merged;
// Expected output words as {idx, val}
logic [31:0] exp_q [$];

function automatic void model_reset();
    for (int i = 0; i < M_DEPTH; i++) begin
        m_valid[i] = 1'b0;
        m_idx[i]   = '0;
        m_val[i]   = '0;
    end
    m_enable = 1'b1;
    m_op     = 2'd0;
    m_occ    = 0;
    m_merged = '0;
    exp_q.delete();
endfunction

// Unsigned min and max, anything else adds with wrap
function automatic logic [15:0] combine(input logic [1:0] op, input logic [15:0] old_v,
                                        input logic [15:0] new_v);
    case (op)
        2'd1:    return (new_v < old_v) ? new_v : old_v;
        2'd2:    return (new_v > old_v) ? new_v : old_v;
        default: return old_v + new_v;
    endcase
endfunction

function automatic void model_ctrl(input logic [15:0] data);
    m_enable = data[0];
    m_op     = data[2:1];
endfunction

function automatic void model_event(input logic [15:0] idx, input logic [15:0] val);
    int slot;
    slot = int'(idx[M_SLOT_W-1:0]);
    if (!m_enable) begin
        // Bypass straight through
        exp_q.push_back({idx, val});
    end else if (m_valid[slot] && (m_idx[slot] == idx)) begin
        m_val[slot] = combine(m_op, m_val[slot], val);
        m_merged    = m_merged + 16'd1;
    end else begin
        if (m_valid[slot]) begin
            // Older entry leaves first
            exp_q.push_back({m_idx[slot], m_val[slot]});
        end else begin
            m_occ++;
        end
        m_valid[slot] = 1'b1;
        m_idx[slot]   = idx;
        m_val[slot]   = val;
    end
endfunction

// Drain in ascending slot order
function automatic void model_flush();
    for (int i = 0; i < M_DEPTH; i++) begin
        if (m_valid[i]) begin
            exp_q.push_back({m_idx[i], m_val[i]});
            m_valid[i] = 1'b0;
        end
    end
    m_occ = 0;
endfunction

`endif

//--- tests/cu_tb.sv
`timescale 1ns/10ps

module cu_tb;

    import cu_pkg::*;

    typedef enum int {K_CFG, K_EVENT, K_FLUSH, K_DRAIN, K_STALL} row_kind_e;

    // DUT signals
    logic        clk_i;
    logic        rst_i;
    logic        ev_wr_en_i;
    logic [15:0] ev_idx_i;
    logic [15:0] ev_val_i;
    logic        ev_ready_o;
    logic        out_rd_en_i;
    logic        out_valid_o;
    logic [15:0] out_idx_o;
    logic [15:0] out_val_o;
    logic        out_empty_o;
    logic        cfg_we_i;
    cu_reg_e     cfg_addr_i;
    logic [15:0] cfg_wdata_i;
    logic [15:0] cfg_rdata_o;

    // Stimulus table, one entry per row
    row_kind_e   row_kind [$];
    logic [15:0] row_a    [$];
    logic [15:0] row_d    [$];
    int          row_test [$];

    int err_cnt;
    int tests_run;
    int tests_failed;
    bit drain_hold;
    bit table_ready;

    `include "cu_tb_model.svh"

    cu_top dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ev_wr_en_i  (ev_wr_en_i),
        .ev_idx_i    (ev_idx_i),
        .ev_val_i    (ev_val_i),
        .ev_ready_o  (ev_ready_o),
        .out_rd_en_i (out_rd_en_i),
        .out_valid_o (out_valid_o),
        .out_idx_o   (out_idx_o),
        .out_val_o   (out_val_o),
        .out_empty_o (out_empty_o),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

    // ----------------------------------------
    // Table building
    // ----------------------------------------
    task automatic add_row(input row_kind_e kind, input logic [15:0] a, input logic [15:0] d,
                           input int test);
        row_kind.push_back(kind);
        row_a.push_back(a);
        row_d.push_back(d);
        row_test.push_back(test);
    endtask

    task automatic build_table();
        // Reset values only
        add_row(K_DRAIN, 16'h0, 16'h0, 1);
        // Add merge with a sum that wraps
        add_row(K_CFG, REG_CTRL, 16'h0001, 2);
        add_row(K_EVENT, 16'h0105, 16'hfff0, 2);
        add_row(K_EVENT, 16'h0105, 16'h0020, 2);
        add_row(K_EVENT, 16'h0105, 16'h0007, 2);
        add_row(K_EVENT, 16'h0105, 16'h8000, 2);
        add_row(K_DRAIN, 16'h0, 16'h0, 2);
        add_row(K_FLUSH, 16'h0, 16'h0, 2);
        add_row(K_DRAIN, 16'h0, 16'h0, 2);
        // Slot conflicts on slots 1 and 4
        add_row(K_EVENT, 16'h0001, 16'h1001, 3);
        add_row(K_EVENT, 16'h0009, 16'h1009, 3);
        add_row(K_EVENT, 16'h0011, 16'h1011, 3);
        add_row(K_EVENT, 16'h0004, 16'h1004, 3);
        add_row(K_EVENT, 16'h0012, 16'h1012, 3);
        add_row(K_EVENT, 16'h000c, 16'h100c, 3);
        add_row(K_EVENT, 16'h0009, 16'h2009, 3);
        add_row(K_DRAIN, 16'h0, 16'h0, 3);
        add_row(K_FLUSH, 16'h0, 16'h0, 3);
        add_row(K_DRAIN, 16'h0, 16'h0, 3);
        // MIN then MAX over random values
        add_row(K_CFG, REG_CTRL, 16'h0003, 4);
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 3; j++) begin
                add_row(K_EVENT, 16'h0020 + 16'(j), 16'($urandom()), 4);
            end
        end
        add_row(K_DRAIN, 16'h0, 16'h0, 4);
        add_row(K_FLUSH, 16'h0, 16'h0, 4);
        add_row(K_DRAIN, 16'h0, 16'h0, 4);
        add_row(K_CFG, REG_CTRL, 16'h0005, 4);
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 3; j++) begin
                add_row(K_EVENT, 16'h0030 + 16'(j), 16'($urandom()), 4);
            end
        end
        add_row(K_DRAIN, 16'h0, 16'h0, 4);
        add_row(K_FLUSH, 16'h0, 16'h0, 4);
        add_row(K_DRAIN, 16'h0, 16'h0, 4);
        // Two entries left in table before bypass
        add_row(K_CFG, REG_CTRL, 16'h0001, 5);
        add_row(K_EVENT, 16'h0043, 16'h0abc, 5);
        add_row(K_EVENT, 16'h0046, 16'h0def, 5);
        add_row(K_CFG, REG_CTRL, 16'h0000, 5);
        add_row(K_EVENT, 16'h0043, 16'h1111, 5);
        add_row(K_EVENT, 16'h0050, 16'h2222, 5);
        add_row(K_EVENT, 16'h0051, 16'h3333, 5);
        add_row(K_EVENT, 16'h0043, 16'h4444, 5);
        add_row(K_DRAIN, 16'h0, 16'h0, 5);
        add_row(K_FLUSH, 16'h0, 16'h0, 5);
        add_row(K_DRAIN, 16'h0, 16'h0, 5);
        // One install and four evictions fill the output FIFO
        // Four more fill the input FIFO
        add_row(K_CFG, REG_CTRL, 16'h0001, 6);
        add_row(K_STALL, 16'h0, 16'h1, 6);
        for (int k = 0; k < 9; k++) begin
            add_row(K_EVENT, 16'h0003 + 16'(8 * k), 16'h0100 + 16'(k), 6);
        end
        add_row(K_STALL, 16'h0, 16'h0, 6);
        add_row(K_DRAIN, 16'h0, 16'h0, 6);
        add_row(K_FLUSH, 16'h0, 16'h0, 6);
        add_row(K_DRAIN, 16'h0, 16'h0, 6);
    endtask

    // ----------------------------------------
    // Bus and event helpers
    // ----------------------------------------
    task automatic write_reg(input cu_reg_e addr, input logic [15:0] data);
        @(posedge clk_i);
        #2;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(posedge clk_i);
        #2;
        cfg_we_i = 1'b0;
    endtask

    // Read port is combinational
    task automatic read_reg(input cu_reg_e addr, output logic [15:0] data);
        cfg_addr_i = addr;
        #1;
        data = cfg_rdata_o;
    endtask

    task automatic push_event(input logic [15:0] idx, input logic [15:0] val);
        int waited;
        waited = 0;
        @(posedge clk_i);
        #2;
        while (!ev_ready_o && waited < 200) begin
            @(posedge clk_i);
            #2;
            waited++;
        end
        if (!ev_ready_o) begin
            $display("Event %h could not be pushed: ev_ready_o stayed low", idx);
            err_cnt++;
        end else begin
            ev_wr_en_i = 1'b1;
            ev_idx_i   = idx;
            ev_val_i   = val;
            model_event(idx, val);
            @(posedge clk_i);
            #2;
            ev_wr_en_i = 1'b0;
        end
    endtask

    task automatic run_flush();
        logic [15:0] st;
        int waited;
        bit busy;
        write_reg(REG_CTRL, {12'd0, 1'b1, m_op, m_enable});
        model_flush();
        waited = 0;
        busy   = 1'b1;
        while (busy && waited < 200) begin
            read_reg(REG_STATUS, st);
            busy = st[0];
            if (busy) begin
                @(posedge clk_i);
                #2;
            end
            waited++;
        end
        if (busy) begin
            $display("Flush did not finish: busy bit still high after %0d cycles", waited);
            err_cnt++;
        end
    endtask

    // Wait for outputs and counters to reach the model then check registers
    task automatic settle_check();
        logic [15:0] st;
        logic [15:0] mg;
        logic [15:0] ctrl;
        logic [15:0] exp_st;
        int waited;
        bit settled;
        exp_st  = 16'(m_occ << 1);
        settled = 1'b0;
        waited  = 0;
        while (!settled && waited < 200) begin
            @(posedge clk_i);
            #4;
            read_reg(REG_STATUS, st);
            read_reg(REG_MERGED, mg);
            settled = (exp_q.size() == 0) && out_empty_o && (st == exp_st) && (mg == m_merged);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Output events missing: %0d expected events never appeared", exp_q.size());
            err_cnt++;
        end
        if (st !== exp_st) begin
            $display("Mismatch REG_STATUS: expected %h, got %h", exp_st, st);
            err_cnt++;
        end
        if (mg !== m_merged) begin
            $display("Mismatch REG_MERGED: expected %h, got %h", m_merged, mg);
            err_cnt++;
        end
        read_reg(REG_CTRL, ctrl);
        if (ctrl !== {13'd0, m_op, m_enable}) begin
            $display("Mismatch REG_CTRL: expected %h, got %h", {13'd0, m_op, m_enable}, ctrl);
            err_cnt++;
        end
        if (ev_ready_o !== 1'b1) begin
            $display("Mismatch ev_ready_o: expected %h, got %h", 1'b1, ev_ready_o);
            err_cnt++;
        end
        if (out_empty_o !== 1'b1) begin
            $display("Mismatch out_empty_o: expected %h, got %h", 1'b1, out_empty_o);
            err_cnt++;
        end
    endtask

    // Input side must fill up while the drain is held
    task automatic release_drain();
        int waited;
        waited = 0;
        while (ev_ready_o && waited < 200) begin
            @(posedge clk_i);
            #2;
            waited++;
        end
        if (ev_ready_o) begin
            $display("Back-pressure failed: ev_ready_o stayed high with the drain held");
            err_cnt++;
        end
        drain_hold = 1'b0;
    endtask

    task automatic report_test(input int test, input int errs);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d: %s (%0d errors)", test, (errs == 0) ? "pass" : "FAIL", errs);
    endtask

    // ----------------------------------------
    // Output drain and compare
    // ----------------------------------------
    initial begin : drain_proc
        logic [31:0] exp_word;
        out_rd_en_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #2;
            if (out_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("Extra output event idx %h val %h with none expected",
                             out_idx_o, out_val_o);
                    err_cnt++;
                end else begin
                    exp_word = exp_q.pop_front();
                    if (out_idx_o !== exp_word[31:16]) begin
                        $display("Mismatch out_idx_o: expected %h, got %h",
                                 exp_word[31:16], out_idx_o);
                        err_cnt++;
                    end
                    if (out_val_o !== exp_word[15:0]) begin
                        $display("Mismatch out_val_o: expected %h, got %h",
                                 exp_word[15:0], out_val_o);
                        err_cnt++;
                    end
                end
            end else if (out_idx_o !== 16'h0 || out_val_o !== 16'h0) begin
                // Idle output word must be zero
                $display("Mismatch out_idx_o/out_val_o idle: expected 0000/0000, got %h/%h",
                         out_idx_o, out_val_o);
                err_cnt++;
            end
            out_rd_en_i = !drain_hold && !out_empty_o && !rst_i;
        end
    end

    // Run limit scales with table length
    initial begin : watchdog_proc
        wait (table_ready);
        #(row_kind.size() * 200 * 20);
        $display("Timeout: run still going after %0d rows worth of time", row_kind.size());
        $display("Done: errors found");
        $finish;
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main_proc
        int prev_test;
        int test_errs;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        ev_wr_en_i   = 1'b0;
        ev_idx_i     = '0;
        ev_val_i     = '0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = REG_CTRL;
        cfg_wdata_i  = '0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        drain_hold   = 1'b0;
        void'($urandom(32'he2f8));
        model_reset();
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        prev_test = row_test[0];
        test_errs = err_cnt;
        for (int r = 0; r < row_kind.size(); r++) begin
            if (row_test[r] != prev_test) begin
                report_test(prev_test, err_cnt - test_errs);
                prev_test = row_test[r];
                test_errs = err_cnt;
            end
            case (row_kind[r])
                K_CFG: begin
                    write_reg(cu_reg_e'(row_a[r][1:0]), row_d[r]);
                    if (row_a[r][1:0] == REG_CTRL) begin
                        model_ctrl(row_d[r]);
                    end
                end
                K_EVENT: push_event(row_a[r], row_d[r]);
                K_FLUSH: run_flush();
                K_DRAIN: settle_check();
                K_STALL: begin
                    if (row_d[r][0]) begin
                        drain_hold = 1'b1;
                    end else begin
                        release_drain();
                    end
                end
                default: ;
            endcase
        end
        report_test(prev_test, err_cnt - test_errs);

        if (exp_q.size() != 0) begin
            $display("Run ended with %0d expected output events not seen", exp_q.size());
            err_cnt++;
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+tests
rtl/cu_pkg.sv
rtl/cu_fifo.sv
rtl/cu_regs.sv
rtl/cu_coalescer.sv
rtl/cu_top.sv
tests/cu_tb.sv
